// File: verilog/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    ////////////////////////////////////////
    // Widths that carry a meaning
    ////////////////////////////////////////

    typedef logic [15:0] lc3b_word;             // Data word, address or instruction.
    typedef logic [2:0]  lc3b_reg;              // Register index.
    typedef logic [2:0]  lc3b_aluop;            // ALU operation code.

    localparam int num_regs = 8;                // Size of the register file.

    ////////////////////////////////////////
    // Opcodes, instruction bits 15:12
    ////////////////////////////////////////

    localparam logic [3:0] op_add = 4'b0001;
    localparam logic [3:0] op_and = 4'b0101;
    localparam logic [3:0] op_not = 4'b1001;
    localparam logic [3:0] op_shf = 4'b1101;
    localparam logic [3:0] op_lea = 4'b1110;

    ////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////

    localparam lc3b_aluop alu_add  = 3'd0;
    localparam lc3b_aluop alu_and  = 3'd1;
    localparam lc3b_aluop alu_not  = 3'd2;      // Uses operand A only.
    localparam lc3b_aluop alu_sll  = 3'd3;
    localparam lc3b_aluop alu_srl  = 3'd4;
    localparam lc3b_aluop alu_sra  = 3'd5;
    localparam lc3b_aluop alu_pass = 3'd6;      // Operand B straight through.

    // Operand B sources for the ALU.
    localparam logic [1:0] opb_sr2  = 2'd0;     // Second source register.
    localparam logic [1:0] opb_imm5 = 2'd1;     // Sign-extended 5-bit immediate.
    localparam logic [1:0] opb_imm4 = 2'd2;     // Zero-extended shift amount.

endpackage : lc3b_pkg

`default_nettype wire

// File: verilog/lc3b_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_regfile
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  lc3b_reg  raddr_a,
    input  lc3b_reg  raddr_b,
    output lc3b_word rdata_a,
    output lc3b_word rdata_b,

    input  logic     we,
    input  lc3b_reg  waddr,
    input  lc3b_word wdata
);

    lc3b_word regs [num_regs];                  // Architectural registers R0 to R7.

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;                  // All registers start at zero.
            end
        end else if (we) begin
            regs[waddr] <= wdata;               // Written at the retiring edge.
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // Reads are combinational. A write in flight is not bypassed here,
    // the execute stage forwards from the result register instead.
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule : lc3b_regfile

`default_nettype wire

// File: verilog/lc3b_decode.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_decode
    import lc3b_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       instr_valid,
    output logic       instr_ready,
    input  lc3b_word   instr,
    input  lc3b_word   instr_pc,

    input  logic       res_ready,

    output logic       dec_valid,
    output lc3b_word   dec_ir,
    output lc3b_word   dec_pc,
    output lc3b_aluop  dec_aluop,
    output logic [1:0] dec_opb_sel,
    output logic       dec_use_pcn,
    output logic       dec_we,
    output lc3b_reg    dec_dest,
    output lc3b_reg    dec_sr1,
    output lc3b_reg    dec_sr2
);

    logic       accept;
    lc3b_aluop  nxt_aluop;
    logic [1:0] nxt_opb_sel;
    logic       nxt_use_pcn;
    logic       nxt_we;

    // The decode register can take a new word when it is empty or its
    // current word moves into the result register this cycle.
    assign instr_ready = !dec_valid || res_ready;
    assign accept      = instr_valid && instr_ready;

    ////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////

    always_comb begin
        nxt_aluop   = alu_pass;                 // Unsupported opcodes retire with no write.
        nxt_opb_sel = opb_sr2;
        nxt_use_pcn = 1'b0;
        nxt_we      = 1'b0;
        case (instr[15:12])
            op_add, op_and: begin
                nxt_aluop   = (instr[15:12] == op_add) ? alu_add : alu_and;
                nxt_opb_sel = instr[5] ? opb_imm5 : opb_sr2;    // Bit 5 picks the imm5 form.
                nxt_we      = 1'b1;
            end
            op_not: begin
                nxt_aluop = alu_not;
                nxt_we    = 1'b1;
            end
            op_shf: begin
                nxt_opb_sel = opb_imm4;
                nxt_we      = 1'b1;
                // Bit 4 gives the direction and bit 5 the arithmetic kind.
                case (instr[5:4])
                    2'b01:   nxt_aluop = alu_srl;
                    2'b11:   nxt_aluop = alu_sra;
                    default: nxt_aluop = alu_sll;
                endcase
            end
            op_lea: begin
                nxt_use_pcn = 1'b1;             // Result comes from the PC adder.
                nxt_we      = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Decode register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (accept) begin
            dec_valid <= 1'b1;
        end else if (res_ready) begin
            dec_valid <= 1'b0;                  // Word moved on and nothing replaced it.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_ir      <= instr;
            dec_pc      <= instr_pc + 16'd2;    // Incremented PC for PC-relative forms.
            dec_aluop   <= nxt_aluop;
            dec_opb_sel <= nxt_opb_sel;
            dec_use_pcn <= nxt_use_pcn;
            dec_we      <= nxt_we;
            dec_dest    <= instr[11:9];
            dec_sr1     <= instr[8:6];
            dec_sr2     <= instr[2:0];
        end
    end

endmodule : lc3b_decode

`default_nettype wire

// File: verilog/lc3b_alu.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_alu
    import lc3b_pkg::*;
(
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

    logic [3:0] shamt;

    assign shamt = b[3:0];                      // Shifts use only the low four bits.

    ////////////////////////////////////////
    // Function select
    ////////////////////////////////////////

    always_comb begin
        case (aluop)
            alu_add: begin
                f = a + b;                      // Carry out is dropped.
            end
            alu_and: begin
                f = a & b;
            end
            alu_not: begin
                f = ~a;
            end
            alu_sll: begin
                f = a << shamt;
            end
            alu_srl: begin
                f = a >> shamt;                 // Zero fill from the top.
            end
            alu_sra: begin
                f = $signed(a) >>> shamt;       // Sign bit is copied down.
            end
            alu_pass: begin
                f = b;
            end
            default: begin
                f = '0;
            end
        endcase
    end

endmodule : lc3b_alu

`default_nettype wire

// File: verilog/lc3b_execute.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_execute
    import lc3b_pkg::*;
(
    // From decode.
    input  logic       dec_valid,
    input  lc3b_word   dec_ir,
    input  lc3b_word   dec_pc,
    input  lc3b_aluop  dec_aluop,
    input  logic [1:0] dec_opb_sel,
    input  logic       dec_use_pcn,
    input  logic       dec_we,
    input  lc3b_reg    dec_dest,
    input  lc3b_reg    dec_sr1,
    input  lc3b_reg    dec_sr2,

    // Register file read ports.
    output lc3b_reg    rf_raddr_a,
    output lc3b_reg    rf_raddr_b,
    input  lc3b_word   rf_data_a,
    input  lc3b_word   rf_data_b,

    // Forwarding from the result register.
    input  logic       fwd_valid,
    input  logic       fwd_we,
    input  lc3b_reg    fwd_dest,
    input  lc3b_word   fwd_data,

    // ALU operands and result.
    output lc3b_aluop  alu_op,
    output lc3b_word   alu_a,
    output lc3b_word   alu_b,
    input  lc3b_word   alu_f,

    // To result.
    output logic       exe_valid,
    output logic       exe_we,
    output lc3b_reg    exe_dest,
    output lc3b_word   exe_pc,
    output lc3b_word   exe_value
);

    lc3b_word imm4;
    lc3b_word imm5;
    lc3b_word offset9;
    lc3b_word src_a;
    lc3b_word src_b;
    lc3b_word opb;
    lc3b_word pcn;
    logic     fwd_hit_a;
    logic     fwd_hit_b;

    ////////////////////////////////////////
    // Immediates
    ////////////////////////////////////////

    assign imm4    = {12'd0, dec_ir[3:0]};                      // Shift amount.
    assign imm5    = {{11{dec_ir[4]}}, dec_ir[4:0]};
    assign offset9 = {{6{dec_ir[8]}}, dec_ir[8:0], 1'b0};       // Word offset in bytes.

    ////////////////////////////////////////
    // Operand fetch and forwarding
    ////////////////////////////////////////

    assign rf_raddr_a = dec_sr1;
    assign rf_raddr_b = dec_sr2;

    // The result register is the only place a value can wait before it
    // reaches the register file, so one compare per source covers every hazard.
    assign fwd_hit_a = fwd_valid && fwd_we && (fwd_dest == dec_sr1);
    assign fwd_hit_b = fwd_valid && fwd_we && (fwd_dest == dec_sr2);

    assign src_a = fwd_hit_a ? fwd_data : rf_data_a;
    assign src_b = fwd_hit_b ? fwd_data : rf_data_b;

    always_comb begin
        case (dec_opb_sel)
            opb_imm5: opb = imm5;
            opb_imm4: opb = imm4;
            default:  opb = src_b;                              // Register form.
        endcase
    end

    ////////////////////////////////////////
    // ALU and PC adder
    ////////////////////////////////////////

    assign alu_op = dec_aluop;
    assign alu_a  = src_a;
    assign alu_b  = opb;

    assign pcn = dec_pc + offset9;                              // Target for LEA.

    ////////////////////////////////////////
    // Outputs to the result stage
    ////////////////////////////////////////

    assign exe_valid = dec_valid;
    assign exe_we    = dec_we;
    assign exe_dest  = dec_dest;
    assign exe_pc    = dec_pc - 16'd2;                          // Back to the fetch address.

    always_comb begin
        if (!dec_we) begin
            exe_value = '0;                                     // Unsupported opcode.
        end else if (dec_use_pcn) begin
            exe_value = pcn;
        end else begin
            exe_value = alu_f;
        end
    end

endmodule : lc3b_execute

`default_nettype wire

// File: verilog/lc3b_result.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_result
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  logic     exe_valid,
    input  logic     exe_we,
    input  lc3b_reg  exe_dest,
    input  lc3b_word exe_pc,
    input  lc3b_word exe_value,

    output logic     wb_valid,
    input  logic     wb_ready,
    output lc3b_word wb_pc,
    output logic     wb_we,
    output lc3b_reg  wb_dest,
    output lc3b_word wb_data,

    output logic     res_ready,
    output logic     rf_we
);

    logic retire;

    assign retire    = wb_valid && wb_ready;    // Writeback handshake.
    assign res_ready = !wb_valid || wb_ready;   // Empty or retiring this cycle.

    // Commit to the register file only when the consumer takes the result.
    assign rf_we = retire && wb_we;

    ////////////////////////////////////////
    // Result register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (res_ready) begin
            wb_valid <= exe_valid;              // Drops when nothing follows.
        end
    end

    always_ff @(posedge clk) begin
        if (res_ready && exe_valid) begin
            wb_pc   <= exe_pc;
            wb_we   <= exe_we;
            wb_dest <= exe_dest;
            wb_data <= exe_value;
        end
    end

endmodule : lc3b_result

`default_nettype wire

// File: verilog/lc3b_core.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_core
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  logic     instr_valid,
    output logic     instr_ready,
    input  lc3b_word instr,
    input  lc3b_word instr_pc,

    output logic     wb_valid,
    input  logic     wb_ready,
    output lc3b_word wb_pc,
    output logic     wb_we,
    output lc3b_reg  wb_dest,
    output lc3b_word wb_data
);

    logic       res_ready;
    logic       dec_valid;
    lc3b_word   dec_ir;
    lc3b_word   dec_pc;
    lc3b_aluop  dec_aluop;
    logic [1:0] dec_opb_sel;
    logic       dec_use_pcn;
    logic       dec_we;
    lc3b_reg    dec_dest;
    lc3b_reg    dec_sr1;
    lc3b_reg    dec_sr2;
    lc3b_reg    rf_raddr_a;
    lc3b_reg    rf_raddr_b;
    lc3b_word   rf_data_a;
    lc3b_word   rf_data_b;
    logic       rf_we;
    lc3b_aluop  alu_op;
    lc3b_word   alu_a;
    lc3b_word   alu_b;
    lc3b_word   alu_f;
    logic       exe_valid;
    logic       exe_we;
    lc3b_reg    exe_dest;
    lc3b_word   exe_pc;
    lc3b_word   exe_value;

    ////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////

    lc3b_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .res_ready   (res_ready),
        .dec_valid   (dec_valid),
        .dec_ir      (dec_ir),
        .dec_pc      (dec_pc),
        .dec_aluop   (dec_aluop),
        .dec_opb_sel (dec_opb_sel),
        .dec_use_pcn (dec_use_pcn),
        .dec_we      (dec_we),
        .dec_dest    (dec_dest),
        .dec_sr1     (dec_sr1),
        .dec_sr2     (dec_sr2)
    );

    lc3b_execute u_execute (
        .dec_valid   (dec_valid),
        .dec_ir      (dec_ir),
        .dec_pc      (dec_pc),
        .dec_aluop   (dec_aluop),
        .dec_opb_sel (dec_opb_sel),
        .dec_use_pcn (dec_use_pcn),
        .dec_we      (dec_we),
        .dec_dest    (dec_dest),
        .dec_sr1     (dec_sr1),
        .dec_sr2     (dec_sr2),
        .rf_raddr_a  (rf_raddr_a),
        .rf_raddr_b  (rf_raddr_b),
        .rf_data_a   (rf_data_a),
        .rf_data_b   (rf_data_b),
        .fwd_valid   (wb_valid),                // The result register is the forwarding source.
        .fwd_we      (wb_we),
        .fwd_dest    (wb_dest),
        .fwd_data    (wb_data),
        .alu_op      (alu_op),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_f       (alu_f),
        .exe_valid   (exe_valid),
        .exe_we      (exe_we),
        .exe_dest    (exe_dest),
        .exe_pc      (exe_pc),
        .exe_value   (exe_value)
    );

    lc3b_alu u_alu (
        .aluop (alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    lc3b_result u_result (
        .clk       (clk),
        .reset     (reset),
        .exe_valid (exe_valid),
        .exe_we    (exe_we),
        .exe_dest  (exe_dest),
        .exe_pc    (exe_pc),
        .exe_value (exe_value),
        .wb_valid  (wb_valid),
        .wb_ready  (wb_ready),
        .wb_pc     (wb_pc),
        .wb_we     (wb_we),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data),
        .res_ready (res_ready),
        .rf_we     (rf_we)
    );

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////

    lc3b_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .raddr_a (rf_raddr_a),
        .raddr_b (rf_raddr_b),
        .rdata_a (rf_data_a),
        .rdata_b (rf_data_b),
        .we      (rf_we),
        .waddr   (wb_dest),                     // Write address and data come from the result register.
        .wdata   (wb_data)
    );

endmodule : lc3b_core

`default_nettype wire

// File: dv/lc3b_ref_model.svh
`ifndef LC3B_REF_MODEL_SVH
`define LC3B_REF_MODEL_SVH

////////////////////////////////////////
// Shadow architectural state
////////////////////////////////////////

lc3b_word shadow_regs [num_regs];               // Mirrors R0 to R7 in program order.

task automatic model_reset();
    for (int i = 0; i < num_regs; i++) begin
        shadow_regs[i] = '0;                    // Registers come out of reset as zero.
    end
endtask

// Takes the low width bits of field as a two's complement number.
function automatic lc3b_word sign_extend(input lc3b_word field, input int width);
    int value;
    value = int'(field);
    if (field[width-1]) begin
        value = value - (1 << width);
    end
    return value[15:0];
endfunction

// One bit at a time, copying the sign bit into the top.
function automatic lc3b_word shift_right_arith(input lc3b_word value, input int amount);
    lc3b_word result;
    result = value;
    for (int i = 0; i < amount; i++) begin
        result = {result[15], result[15:1]};
    end
    return result;
endfunction

////////////////////////////////////////
// Instruction semantics
////////////////////////////////////////

task automatic model_step(input lc3b_word ir, input lc3b_word pc,
                          output logic we, output lc3b_reg dest, output lc3b_word data);
    lc3b_word a;
    lc3b_word b;
    int       amount;
    dest   = ir[11:9];
    a      = shadow_regs[ir[8:6]];
    b      = ir[5] ? sign_extend(ir[4:0], 5) : shadow_regs[ir[2:0]];
    amount = int'(ir[3:0]);
    we     = 1'b1;
    data   = '0;
    case (ir[15:12])
        op_add: data = a + b;
        op_and: data = a & b;
        op_not: data = ~a;
        op_shf: begin
            if (!ir[4]) begin
                data = a << amount;
            end else if (!ir[5]) begin
                data = a >> amount;             // Logical, zero fill.
            end else begin
                data = shift_right_arith(a, amount);
            end
        end
        op_lea: data = pc + 16'd2 + (sign_extend(ir[8:0], 9) << 1);
        default: we = 1'b0;                     // Retires with no write and zero data.
    endcase
    if (we) begin
        shadow_regs[dest] = data;
    end
endtask

`endif

// File: dv/lc3b_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_core_tb
    import lc3b_pkg::*;
();

    localparam int       num_tests     = 28;
    localparam int       timeout_limit = 20 * num_tests + 50;
    localparam lc3b_word pc_base       = 16'h3000;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic        instr_ready;
    lc3b_word    instr;
    lc3b_word    instr_pc;
    logic        wb_valid;
    logic        wb_ready;
    lc3b_word    wb_pc;
    logic        wb_we;
    lc3b_reg     wb_dest;
    lc3b_word    wb_data;

    lc3b_word    stim_tab [num_tests];
    lc3b_word    pc_tab   [num_tests];
    logic        exp_we   [num_tests];
    lc3b_reg     exp_dest [num_tests];
    lc3b_word    exp_data [num_tests];

    int          retired;
    int          cycles;
    logic        random_phase;                  // Second half of the table runs with gaps and stalls.
    int unsigned seed_draw;

    `include "lc3b_ref_model.svh"

    lc3b_core dut0 (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb_pc       (wb_pc),
        .wb_we       (wb_we),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input lc3b_word actual, input lc3b_word expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("[ERROR] %s: got 0x%04h, expected 0x%04h",
                                      name, actual, expected));
        end
    endtask

    task automatic load_table();
        stim_tab[0]  = 16'h1227;                // ADD R1, R0, #7 reads R0 before any write.
        stim_tab[1]  = 16'h147D;                // ADD R2, R1, #-3.
        stim_tab[2]  = 16'h1642;                // ADD R3, R1, R2 at distances two and one.
        stim_tab[3]  = 16'h58FE;                // AND R4, R3, #-2.
        stim_tab[4]  = 16'h5AC4;                // AND R5, R3, R4.
        stim_tab[5]  = 16'h9D7F;                // NOT R6, R5.
        stim_tab[6]  = 16'hDF84;                // SHF R7, R6, left by 4.
        stim_tab[7]  = 16'hD3D3;                // SHF R1, R7, logical right by 3.
        stim_tab[8]  = 16'hD5F5;                // SHF R2, R7, arithmetic right by 5.
        stim_tab[9]  = 16'hE60A;                // LEA R3, +10.
        stim_tab[10] = 16'hE9FC;                // LEA R4, -4.
        stim_tab[11] = 16'h0E05;                // Unsupported branch opcode.
        stim_tab[12] = 16'h1AC4;                // ADD R5, R3, R4.
        stim_tab[13] = 16'h6A40;                // Unsupported load opcode.
        stim_tab[14] = 16'h1B6F;                // ADD R5, R5, #15.
        stim_tab[15] = 16'hDD4F;                // SHF R6, R5, left by 15.
        stim_tab[16] = 16'hDDBF;                // SHF R6, R6, arithmetic right by 15.
        stim_tab[17] = 16'h51BF;                // AND R0, R6, #-1.
        stim_tab[18] = 16'h1000;                // ADD R0, R0, R0.
        stim_tab[19] = 16'h923F;                // NOT R1, R0.
        stim_tab[20] = 16'h1470;                // ADD R2, R1, #-16.
        stim_tab[21] = 16'hD690;                // SHF R3, R2, logical right by 0.
        stim_tab[22] = 16'hEF00;                // LEA R7, -256.
        stim_tab[23] = 16'hEEFF;                // LEA R7, +255.
        stim_tab[24] = 16'h19C7;                // ADD R4, R7, R7.
        stim_tab[25] = 16'h5B03;                // AND R5, R4, R3.
        stim_tab[26] = 16'hF025;                // Unsupported trap opcode.
        stim_tab[27] = 16'h1D44;                // ADD R6, R5, R4.
    endtask

    task automatic build_expected();
        model_reset();
        for (int i = 0; i < num_tests; i++) begin
            pc_tab[i] = pc_base + lc3b_word'(2 * i);
            model_step(stim_tab[i], pc_tab[i], exp_we[i], exp_dest[i], exp_data[i]);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        seed_draw    = $urandom(43806);
        clk          = 1'b0;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        instr_pc     = '0;
        wb_ready     = 1'b0;
        retired      = 0;
        cycles       = 0;
        random_phase = 1'b0;
        load_table();
        build_expected();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("wb_valid", wb_valid, 1'b0);
        check_value("instr_ready", instr_ready, 1'b1);
        for (int i = 0; i < num_tests; i++) begin
            random_phase = (i >= num_tests / 2);
            while (random_phase && ($urandom % 4) == 0) begin
                instr_valid = 1'b0;             // A gap in the input stream.
                @(negedge clk);
            end
            instr_valid = 1'b1;
            instr       = stim_tab[i];
            instr_pc    = pc_tab[i];
            do begin
                @(posedge clk);
            end while (!instr_ready);
            @(negedge clk);
        end
        instr_valid = 1'b0;
        while (retired < num_tests) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);
        if (!wb_valid) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_on_failure("The pipeline kept an instruction after the whole table retired.");
        end
    end

    always @(negedge clk) begin
        if (random_phase) begin
            wb_ready = ($urandom % 3) != 0;     // Consumer stalls about a third of the time.
        end else begin
            wb_ready = 1'b1;
        end
    end

    ////////////////////////////////////////
    // Monitor and timeout
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!reset && wb_valid && wb_ready) begin
            if (retired >= num_tests) begin
                stop_on_failure("An instruction retired after every table entry had retired.");
            end else begin
                check_value("wb_pc", wb_pc, pc_tab[retired]);
                check_value("wb_we", wb_we, exp_we[retired]);
                if (exp_we[retired]) begin
                    check_value("wb_dest", wb_dest, exp_dest[retired]);
                end
                check_value("wb_data", wb_data, exp_data[retired]);
                retired++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_limit) begin
            stop_on_failure($sformatf("Timed out after %0d cycles with %0d of %0d retired.",
                                      cycles, retired, num_tests));
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+dv
verilog/lc3b_pkg.sv
verilog/lc3b_regfile.sv
verilog/lc3b_decode.sv
verilog/lc3b_alu.sv
verilog/lc3b_execute.sv
verilog/lc3b_result.sv
verilog/lc3b_core.sv
dv/lc3b_core_tb.sv
